/* design/ppu_cfg_decode.sv */
// Config word and input status must already be synchronous to VCLK_Tx; outputs follow in 1 cycle
`timescale 1ns/1ns

module ppu_cfg_decode (
  input  logic                            VCLK_Tx,
  input  logic                            nVRST_Tx,
  input  ppu_pkg::ppu_cfg_t               cfg_i,
  input  logic                            pal_i,
  input  logic                            n64_480i_i,
  output ppu_pkg::video_mode_e            video_mode_o,
  output logic                            sync_active_high_o,
  output ppu_pkg::sl_cfg_t                sl_cfg_o,
  output logic [ppu_pkg::SL_STR_W-1:0]    sl_strength_o,
  output logic                            limited_rgb_o
);

  ppu_pkg::video_mode_e mode_ntsc;
  ppu_pkg::video_mode_e mode_pal;
  ppu_pkg::video_mode_e mode_next;
  ppu_pkg::sl_cfg_t     sl_next;
  logic                 force60_ok;
  logic                 force50_ok;

  // ====================
  // Mode candidates
  // ====================

  always_comb begin
    case (cfg_i.target_res)
      ppu_pkg::TARGET_1440P: mode_ntsc = ppu_pkg::VMODE_1440P60;
      ppu_pkg::TARGET_1200P: mode_ntsc = ppu_pkg::VMODE_1200P60;
      ppu_pkg::TARGET_1080P: mode_ntsc = ppu_pkg::VMODE_1080P60;
      ppu_pkg::TARGET_960P:  mode_ntsc = ppu_pkg::VMODE_960P60;
      ppu_pkg::TARGET_720P:  mode_ntsc = ppu_pkg::VMODE_720P60;
      ppu_pkg::TARGET_240P:  mode_ntsc = ppu_pkg::VMODE_240P60;
      // 288P, 480P, 576P and unused codes end up at 480 lines
      default: begin
        if (cfg_i.use_vga_480p) begin
          mode_ntsc = ppu_pkg::VMODE_VGAP60;
        end else begin
          mode_ntsc = ppu_pkg::VMODE_480P60;
        end
      end
    endcase
  end

  always_comb begin
    case (cfg_i.target_res)
      ppu_pkg::TARGET_1440P: mode_pal = ppu_pkg::VMODE_1440P50;
      ppu_pkg::TARGET_1200P: mode_pal = ppu_pkg::VMODE_1200P50;
      ppu_pkg::TARGET_1080P: mode_pal = ppu_pkg::VMODE_1080P50;
      ppu_pkg::TARGET_960P:  mode_pal = ppu_pkg::VMODE_960P50;
      ppu_pkg::TARGET_720P:  mode_pal = ppu_pkg::VMODE_720P50;
      ppu_pkg::TARGET_576P:  mode_pal = ppu_pkg::VMODE_576P50;
      default:               mode_pal = ppu_pkg::VMODE_288P50;
    endcase
  end

  // Forcing is not allowed in low latency mode
  assign force60_ok = cfg_i.force60 && !cfg_i.low_latency &&
                      (cfg_i.target_res != ppu_pkg::TARGET_288P);
  assign force50_ok = cfg_i.force50 && !cfg_i.low_latency &&
                      (cfg_i.target_res != ppu_pkg::TARGET_240P);

  always_comb begin
    if (force60_ok) begin
      mode_next = mode_ntsc;
    end else if (force50_ok) begin
      mode_next = mode_pal;
    end else if (pal_i) begin
      mode_next = mode_pal;
    end else begin
      mode_next = mode_ntsc;
    end
  end

  // 480i set only when running interlaced and not linked to 240p
  assign sl_next = (n64_480i_i && !cfg_i.sl_480i_linked) ? cfg_i.sl_480i : cfg_i.sl_240p;

  // ====================
  // Held outputs
  // ====================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      video_mode_o       <= ppu_pkg::VMODE_480P60;
      sync_active_high_o <= 1'b0;
      sl_cfg_o           <= '0;
      sl_strength_o      <= '0;
      limited_rgb_o      <= 1'b0;
    end else begin
      video_mode_o       <= mode_next;
      // HD modes use positive syncs
      sync_active_high_o <= (mode_next >= ppu_pkg::VMODE_720P60);
      sl_cfg_o           <= sl_next;
      // (s+1)*16-1 is s in the upper nibble and all ones below
      sl_strength_o      <= {sl_next.strength, 4'hf};
      limited_rgb_o      <= cfg_i.limited_rgb;
    end
  end

endmodule

/* design/ppu_pkg.sv */
// Shared types for the VCLK_Tx output path; colour depth is fixed at 8 bits and sl strength at 4
package ppu_pkg;

  // ====================
  // Widths and constants
  // ====================

  // Bits per colour channel
  localparam int COLOR_W = 8;

  // Width of the scanline strength after expansion to (s+1)*16-1
  localparam int SL_STR_W = 8;

  // Limited range output is c*220/256 + 16
  localparam logic [COLOR_W-1:0] LIMIT_COEFF         = 8'd220;
  localparam logic [3:0]         LIMIT_OFFSET_NIBBLE = 4'd1;

  // ====================
  // Enums
  // ====================

  // Requested output resolution from the config word
  typedef enum logic [3:0] {
    TARGET_240P  = 4'd0,
    TARGET_288P  = 4'd1,
    TARGET_480P  = 4'd2,
    TARGET_576P  = 4'd3,
    TARGET_720P  = 4'd4,
    TARGET_960P  = 4'd5,
    TARGET_1080P = 4'd6,
    TARGET_1200P = 4'd7,
    TARGET_1440P = 4'd8
  } target_res_e;

  // Selected output timing with 720p and up ordered at the top
  typedef enum logic [3:0] {
    VMODE_240P60  = 4'd0,
    VMODE_288P50  = 4'd1,
    VMODE_480P60  = 4'd2,
    VMODE_VGAP60  = 4'd3,
    VMODE_576P50  = 4'd4,
    VMODE_720P60  = 4'd5,
    VMODE_720P50  = 4'd6,
    VMODE_960P60  = 4'd7,
    VMODE_960P50  = 4'd8,
    VMODE_1080P60 = 4'd9,
    VMODE_1080P50 = 4'd10,
    VMODE_1200P60 = 4'd11,
    VMODE_1200P50 = 4'd12,
    VMODE_1440P60 = 4'd13,
    VMODE_1440P50 = 4'd14
  } video_mode_e;

  // ====================
  // Structs
  // ====================

  typedef struct packed {
    logic       en;
    logic       thick;
    logic [3:0] strength;
  } sl_cfg_t;

  // Config word synchronous to VCLK_Tx
  typedef struct packed {
    target_res_e target_res;
    logic        use_vga_480p;
    logic        force60;
    logic        force50;
    logic        low_latency;
    logic        limited_rgb;
    logic        sl_480i_linked;
    sl_cfg_t     sl_240p;
    sl_cfg_t     sl_480i;
  } ppu_cfg_t;

  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
  } vid_sync_t;

  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } rgb_t;

endpackage

/* design/ppu_top.sv */
// Output post-processing in the VCLK_Tx domain only; beats in to beats out take 5 cycles
`timescale 1ns/1ns

module ppu_top #(
  parameter int LINE_CNT_W = 11
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  ppu_pkg::ppu_cfg_t    cfg_i,
  input  logic                 pal_i,
  input  logic                 n64_480i_i,
  input  ppu_pkg::vid_sync_t   sync_i,
  input  ppu_pkg::rgb_t        rgb_i,
  output logic                 VSYNC_o,
  output logic                 HSYNC_o,
  output logic                 DE_o,
  output ppu_pkg::rgb_t        rgb_o,
  output ppu_pkg::video_mode_e video_mode_o
);

  logic                           sync_active_high;
  ppu_pkg::sl_cfg_t               sl_cfg;
  logic [ppu_pkg::SL_STR_W-1:0]   sl_strength;
  logic                           limited_rgb;
  ppu_pkg::vid_sync_t             sl_sync;
  ppu_pkg::rgb_t                  sl_rgb;

  // ====================
  // Config decode
  // ====================

  ppu_cfg_decode u_cfg_decode (
    .VCLK_Tx            (VCLK_Tx),
    .nVRST_Tx           (nVRST_Tx),
    .cfg_i              (cfg_i),
    .pal_i              (pal_i),
    .n64_480i_i         (n64_480i_i),
    .video_mode_o       (video_mode_o),
    .sync_active_high_o (sync_active_high),
    .sl_cfg_o           (sl_cfg),
    .sl_strength_o      (sl_strength),
    .limited_rgb_o      (limited_rgb)
  );

  // Two cycles
  scanline_emu #(
    .LINE_CNT_W (LINE_CNT_W)
  ) u_scanline_emu (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .sync_i        (sync_i),
    .rgb_i         (rgb_i),
    .sl_en_i       (sl_cfg.en),
    .sl_thick_i    (sl_cfg.thick),
    .sl_strength_i (sl_strength),
    .sync_o        (sl_sync),
    .rgb_o         (sl_rgb)
  );

  // Three cycles
  video_out_stage u_video_out_stage (
    .VCLK_Tx            (VCLK_Tx),
    .nVRST_Tx           (nVRST_Tx),
    .sync_i             (sl_sync),
    .rgb_i              (sl_rgb),
    .limited_rgb_i      (limited_rgb),
    .sync_active_high_i (sync_active_high),
    .VSYNC_o            (VSYNC_o),
    .HSYNC_o            (HSYNC_o),
    .DE_o               (DE_o),
    .rgb_o              (rgb_o)
  );

endmodule

/* design/scanline_emu.sv */
// Vertical scanlines only; the line count restarts on vsync and assumes one de pulse per line
`timescale 1ns/1ns

module scanline_emu #(
  parameter int LINE_CNT_W = 11
) (
  input  logic                          VCLK_Tx,
  input  logic                          nVRST_Tx,
  input  ppu_pkg::vid_sync_t            sync_i,
  input  ppu_pkg::rgb_t                 rgb_i,
  input  logic                          sl_en_i,
  input  logic                          sl_thick_i,
  input  logic [ppu_pkg::SL_STR_W-1:0]  sl_strength_i,
  output ppu_pkg::vid_sync_t            sync_o,
  output ppu_pkg::rgb_t                 rgb_o
);

  localparam int CW = ppu_pkg::COLOR_W;

  logic [LINE_CNT_W-1:0] line_cnt;
  logic                  de_q;
  logic                  sl_line;

  // Stage 1 registers
  ppu_pkg::vid_sync_t    sync_q;
  logic                  sl_line_q;
  ppu_pkg::rgb_t         rgb_q;
  logic [2*CW-1:0]       prod_r;
  logic [2*CW-1:0]       prod_g;
  logic [2*CW-1:0]       prod_b;

  // Scanline lines give c - floor(c*str/256) and other lines keep c
  function automatic logic [CW-1:0] darken(
    input logic [CW-1:0]   c,
    input logic [2*CW-1:0] p,
    input logic            en
  );
    logic [CW-1:0] res;
    if (en) begin
      res = c - p[2*CW-1:CW];
    end else begin
      res = c;
    end
    return res;
  endfunction

  // ====================
  // Line counter
  // ====================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      line_cnt <= '0;
      de_q     <= 1'b0;
    end else begin
      de_q <= sync_i.de;
      if (sync_i.vsync) begin
        line_cnt <= '0;
      end else if (de_q && !sync_i.de) begin
        // End of an active line
        line_cnt <= line_cnt + 1'b1;
      end
    end
  end

  // Odd lines when thin and lines 2 and 3 of every four when thick
  assign sl_line = sl_en_i && (sl_thick_i ? line_cnt[1] : line_cnt[0]);

  // ====================
  // Darkening pipeline
  // ====================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      sync_q    <= '0;
      sl_line_q <= 1'b0;
      sync_o    <= '0;
    end else begin
      sync_q    <= sync_i;
      sl_line_q <= sl_line;
      sync_o    <= sync_q;
    end
  end

  always_ff @(posedge VCLK_Tx) begin
    // Stage 1 multiplies
    rgb_q  <= rgb_i;
    prod_r <= rgb_i.r * sl_strength_i;
    prod_g <= rgb_i.g * sl_strength_i;
    prod_b <= rgb_i.b * sl_strength_i;
    // Stage 2 subtracts
    rgb_o.r <= darken(rgb_q.r, prod_r, sl_line_q);
    rgb_o.g <= darken(rgb_q.g, prod_g, sl_line_q);
    rgb_o.b <= darken(rgb_q.b, prod_b, sl_line_q);
  end

endmodule

/* design/video_out_stage.sv */
// Fixed 3-cycle latency; polarity and limiting settings are static levels and are not retimed
`timescale 1ns/1ns

module video_out_stage (
  input  logic                        VCLK_Tx,
  input  logic                        nVRST_Tx,
  input  ppu_pkg::vid_sync_t          sync_i,
  input  ppu_pkg::rgb_t               rgb_i,
  input  logic                        limited_rgb_i,
  input  logic                        sync_active_high_i,
  output logic                        VSYNC_o,
  output logic                        HSYNC_o,
  output logic                        DE_o,
  output ppu_pkg::rgb_t               rgb_o
);

  localparam int CW = ppu_pkg::COLOR_W;

  logic [2*CW-1:0]    mul_r;
  logic [2*CW-1:0]    mul_g;
  logic [2*CW-1:0]    mul_b;
  logic [CW:0]        lim1_r;
  logic [CW:0]        lim1_g;
  logic [CW:0]        lim1_b;
  ppu_pkg::rgb_t      lim2;
  ppu_pkg::rgb_t      full1;
  ppu_pkg::rgb_t      full2;
  ppu_pkg::vid_sync_t sync_d1;
  ppu_pkg::vid_sync_t sync_d2;

  // Add 16 by bumping the upper nibble
  function automatic logic [CW-1:0] add_offset(input logic [CW-1:0] c);
    return {c[CW-1:4] + ppu_pkg::LIMIT_OFFSET_NIBBLE, c[3:0]};
  endfunction

  assign mul_r = rgb_i.r * ppu_pkg::LIMIT_COEFF;
  assign mul_g = rgb_i.g * ppu_pkg::LIMIT_COEFF;
  assign mul_b = rgb_i.b * ppu_pkg::LIMIT_COEFF;

  // ====================
  // Colour pipeline
  // ====================

  always_ff @(posedge VCLK_Tx) begin
    // Keep one extra bit below the result for rounding
    lim1_r <= mul_r[2*CW-1:CW-1];
    lim1_g <= mul_g[2*CW-1:CW-1];
    lim1_b <= mul_b[2*CW-1:CW-1];
    full1  <= rgb_i;

    lim2.r <= lim1_r[CW:1] + lim1_r[0];
    lim2.g <= lim1_g[CW:1] + lim1_g[0];
    lim2.b <= lim1_b[CW:1] + lim1_b[0];
    full2  <= full1;
  end

  // ====================
  // Output registers
  // ====================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      sync_d1 <= '0;
      sync_d2 <= '0;
      VSYNC_o <= 1'b0;
      HSYNC_o <= 1'b0;
      DE_o    <= 1'b0;
      rgb_o   <= '0;
    end else begin
      sync_d1 <= sync_i;
      sync_d2 <= sync_d1;
      // Input syncs are active high, flip them for SD modes
      VSYNC_o <= sync_d2.vsync ^ ~sync_active_high_i;
      HSYNC_o <= sync_d2.hsync ^ ~sync_active_high_i;
      DE_o    <= sync_d2.de;
      if (limited_rgb_i) begin
        rgb_o.r <= add_offset(lim2.r);
        rgb_o.g <= add_offset(lim2.g);
        rgb_o.b <= add_offset(lim2.b);
      end else begin
        rgb_o <= full2;
      end
    end
  end

endmodule

/* dv/ppu_vectors.txt */
// tgt flags{vga,f60,f50,lowlat,limited,linked} sl240 sl480i{en,thick,str} pal i480 rgb_in
// exp_mode exp_pol line_mask(bit n = line n darkened) rgb_normal rgb_scanline
0 00 27 00 0 0 FF8040 0 0 2A FF8040 814121
1 00 33 00 1 0 FF8040 1 0 0C FF8040 C16131
2 00 20 00 0 0 FF8040 2 0 2A FF8040 F1793D
2 20 2F 00 0 0 FF8040 3 0 2A FF8040 010101
3 00 07 00 0 0 FF8040 2 0 00 FF8040 FF8040
3 00 27 00 1 0 00FF80 4 0 2A 00FF80 008141
4 00 27 00 0 0 FF8040 5 1 2A FF8040 814121
4 00 33 00 1 0 FF8040 6 1 0C FF8040 C16131
5 00 27 00 0 0 00FF80 7 1 2A 00FF80 008141
5 00 2F 00 1 0 FF8040 8 1 2A FF8040 010101
6 00 27 00 0 0 FF8040 9 1 2A FF8040 814121
6 00 20 00 1 0 FF8040 A 1 2A FF8040 F1793D
7 00 27 00 0 0 FF8040 B 1 2A FF8040 814121
7 00 33 00 1 0 FF8040 C 1 0C FF8040 C16131
8 00 27 00 0 0 00FF80 D 1 2A 00FF80 008141
8 00 27 00 1 0 FF8040 E 1 2A FF8040 814121
6 10 27 00 1 0 FF8040 9 1 2A FF8040 814121
6 14 27 00 1 0 FF8040 A 1 2A FF8040 814121
6 08 27 00 0 0 FF8040 A 1 2A FF8040 814121
6 0C 27 00 0 0 FF8040 9 1 2A FF8040 814121
1 10 27 00 1 0 FF8040 1 0 2A FF8040 814121
0 08 27 00 0 0 FF8040 0 0 2A FF8040 814121
0 18 27 00 1 0 FF8040 0 0 2A FF8040 814121
3 08 27 00 0 0 FF8040 4 0 2A FF8040 814121
2 28 27 00 0 0 FF8040 1 0 2A FF8040 814121
2 00 27 33 0 1 FF8040 2 0 0C FF8040 C16131
2 01 27 33 0 1 FF8040 2 0 2A FF8040 814121
2 00 27 33 0 0 FF8040 2 0 2A FF8040 814121
2 00 27 07 0 1 FF8040 2 0 00 FF8040 FF8040
2 00 07 2F 0 1 FF8040 2 0 2A FF8040 010101
4 02 27 00 0 0 FF8040 5 1 2A EB7E47 7F482C
2 02 2F 00 0 0 00FF80 2 0 2A 10EB7E 101111
2 02 33 00 1 0 FF8040 1 0 0C EB7E47 B6633A
8 02 27 00 1 0 00FF80 E 1 2A 10EB7E 107F48

/* dv/tb_ppu_top.sv */
// Reads dv/ppu_vectors.txt from the project root; each case holds its config for one 6-line frame
`timescale 1ns/1ns

module tb_ppu_top;

  localparam int CLK_HALF    = 20;
  localparam int DRV_DLY     = 5;
  localparam int PIPE_LAT    = 5;
  localparam int MAX_CASES   = 64;
  localparam int NF          = 12;
  localparam int N_LINES     = 6;
  localparam int LINE_PIX    = 16;
  localparam int LINE_BLANK  = 4;
  localparam int CASE_CYCLES = 200;

  // Column positions within one vector line
  localparam int F_TGT   = 0;
  localparam int F_FLAGS = 1;
  localparam int F_SL240 = 2;
  localparam int F_SL480 = 3;
  localparam int F_PAL   = 4;
  localparam int F_I480  = 5;
  localparam int F_RGB   = 6;
  localparam int F_MODE  = 7;
  localparam int F_POL   = 8;
  localparam int F_MASK  = 9;
  localparam int F_NORM  = 10;
  localparam int F_DARK  = 11;

  logic                 VCLK_Tx;
  logic                 nVRST_Tx;
  ppu_pkg::ppu_cfg_t    cfg_i;
  logic                 pal_i;
  logic                 n64_480i_i;
  ppu_pkg::vid_sync_t   sync_i;
  ppu_pkg::rgb_t        rgb_i;
  logic                 VSYNC_o;
  logic                 HSYNC_o;
  logic                 DE_o;
  ppu_pkg::rgb_t        rgb_o;
  ppu_pkg::video_mode_e video_mode_o;

  logic [31:0]   vec_mem [0:MAX_CASES*NF-1];
  int            n_cases;
  int            n_errors;
  int            n_checks;
  int            cyc;
  bit            loaded;

  // Expectations of the case being run
  int            case_idx;
  logic [3:0]    cur_mode;
  logic          cur_pol;
  logic [5:0]    cur_mask;
  ppu_pkg::rgb_t cur_in;
  ppu_pkg::rgb_t cur_norm;
  ppu_pkg::rgb_t cur_dark;

  // Expected outputs indexed by drive cycle modulo 8
  bit                 exp_chk  [0:7];
  bit                 exp_col  [0:7];
  ppu_pkg::vid_sync_t exp_sync [0:7];
  ppu_pkg::rgb_t      exp_rgb  [0:7];
  int                 exp_line [0:7];
  int                 exp_case [0:7];

  ppu_top #(
    .LINE_CNT_W (11)
  ) DUT (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .cfg_i        (cfg_i),
    .pal_i        (pal_i),
    .n64_480i_i   (n64_480i_i),
    .sync_i       (sync_i),
    .rgb_i        (rgb_i),
    .VSYNC_o      (VSYNC_o),
    .HSYNC_o      (HSYNC_o),
    .DE_o         (DE_o),
    .rgb_o        (rgb_o),
    .video_mode_o (video_mode_o)
  );

  always #CLK_HALF VCLK_Tx = ~VCLK_Tx;

  always @(posedge VCLK_Tx) begin
    cyc <= cyc + 1;
  end

  // ====================
  // Stimulus tasks
  // ====================

  // One beat together with what should leave the DUT PIPE_LAT cycles later
  task automatic drive_beat(input logic vs, input logic hs, input logic de, input bit chk,
                            input bit col_chk, input ppu_pkg::rgb_t exp_c, input int line);
    int slot;
    @(posedge VCLK_Tx);
    #DRV_DLY;
    slot = cyc % 8;
    sync_i.vsync = vs;
    sync_i.hsync = hs;
    sync_i.de    = de;
    rgb_i        = de ? cur_in : '0;
    exp_chk[slot]  = chk;
    exp_col[slot]  = col_chk;
    exp_sync[slot] = {(cur_pol ? vs : ~vs), (cur_pol ? hs : ~hs), de};
    exp_rgb[slot]  = exp_c;
    exp_line[slot] = line;
    exp_case[slot] = case_idx;
  endtask

  task automatic load_case(input int k);
    int base;
    base     = k * NF;
    case_idx = k;
    cfg_i.target_res = ppu_pkg::target_res_e'(vec_mem[base+F_TGT][3:0]);
    {cfg_i.use_vga_480p, cfg_i.force60, cfg_i.force50, cfg_i.low_latency,
     cfg_i.limited_rgb, cfg_i.sl_480i_linked} = vec_mem[base+F_FLAGS][5:0];
    cfg_i.sl_240p = vec_mem[base+F_SL240][5:0];
    cfg_i.sl_480i = vec_mem[base+F_SL480][5:0];
    pal_i      = vec_mem[base+F_PAL][0];
    n64_480i_i = vec_mem[base+F_I480][0];
    cur_in     = vec_mem[base+F_RGB][23:0];
    cur_mode   = vec_mem[base+F_MODE][3:0];
    cur_pol    = vec_mem[base+F_POL][0];
    cur_mask   = vec_mem[base+F_MASK][5:0];
    cur_norm   = vec_mem[base+F_NORM][23:0];
    cur_dark   = vec_mem[base+F_DARK][23:0];
  endtask

  // Vsync and then lines of active pixels that each end in a blank gap with an hsync pulse
  task automatic send_frame();
    ppu_pkg::rgb_t exp_c;
    int            ln;
    int            b;
    repeat (2) drive_beat(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, '0, 0);
    for (ln = 0; ln < N_LINES; ln++) begin
      exp_c = cur_mask[ln] ? cur_dark : cur_norm;
      repeat (LINE_PIX) drive_beat(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, exp_c, ln);
      for (b = 0; b < LINE_BLANK; b++) begin
        drive_beat(1'b0, (b == 1 || b == 2), 1'b0, 1'b1, 1'b0, '0, ln);
      end
    end
  endtask

  task automatic check_reset_outputs();
    if ({VSYNC_o, HSYNC_o, DE_o} !== 3'b000 || rgb_o !== '0) begin
      n_errors++;
      $display("ERR %0t: outputs in reset vs/hs/de=%b rgb=%h, expected all 0",
               $time, {VSYNC_o, HSYNC_o, DE_o}, rgb_o);
    end
    if (video_mode_o !== ppu_pkg::VMODE_480P60) begin
      n_errors++;
      $display("ERR %0t: video_mode_o in reset is %0d, expected 480p60", $time, video_mode_o);
    end
  endtask

  task automatic check_mode();
    if (video_mode_o !== cur_mode) begin
      n_errors++;
      $display("ERR %0t: case %0d video_mode_o=%0d expected %0d",
               $time, case_idx, video_mode_o, cur_mode);
    end
  endtask

  // ====================
  // Output checker
  // ====================

  always @(negedge VCLK_Tx) begin : check_outputs
    int slot;
    if (cyc >= PIPE_LAT) begin
      slot = (cyc - PIPE_LAT) % 8;
      if (exp_chk[slot]) begin
        n_checks++;
        if ({VSYNC_o, HSYNC_o, DE_o} !== exp_sync[slot]) begin
          n_errors++;
          $display("ERR %0t: case %0d line %0d vs/hs/de=%b expected %b", $time,
                   exp_case[slot], exp_line[slot], {VSYNC_o, HSYNC_o, DE_o}, exp_sync[slot]);
        end
        if (exp_col[slot] && rgb_o !== exp_rgb[slot]) begin
          n_errors++;
          $display("ERR %0t: case %0d line %0d rgb_o=%h expected %h", $time,
                   exp_case[slot], exp_line[slot], rgb_o, exp_rgb[slot]);
        end
      end
    end
  end

  // ====================
  // Main sequence
  // ====================

  initial begin : run_cases
    int k;
    VCLK_Tx    = 1'b0;
    nVRST_Tx   = 1'b0;
    cfg_i      = '0;
    pal_i      = 1'b0;
    n64_480i_i = 1'b0;
    sync_i     = '0;
    rgb_i      = '0;
    cyc        = 0;
    n_errors   = 0;
    n_checks   = 0;
    case_idx   = 0;
    cur_pol    = 1'b0;
    cur_in     = '0;
    foreach (exp_chk[i]) exp_chk[i] = 1'b0;
    $readmemh("dv/ppu_vectors.txt", vec_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && !$isunknown(vec_mem[n_cases*NF])) n_cases++;
    loaded = 1'b1;
    repeat (5) @(posedge VCLK_Tx);
    #DRV_DLY;
    check_reset_outputs();
    nVRST_Tx = 1'b1;
    if (n_cases == 0) begin
      n_errors++;
      $display("No test vectors could be read from dv/ppu_vectors.txt");
    end
    for (k = 0; k < n_cases; k++) begin
      load_case(k);
      // Config settles before the frame starts
      repeat (3) drive_beat(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, 0);
      check_mode();
      send_frame();
      // Let the last checked beats leave the pipeline
      repeat (PIPE_LAT + 1) drive_beat(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, 0);
    end
    $display("Cases: %0d, checks: %0d, errors: %0d", n_cases, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : watchdog
    longint limit_ns;
    wait (loaded);
    limit_ns = (longint'(n_cases) * CASE_CYCLES + 50) * 2 * CLK_HALF;
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns and was stopped", limit_ns);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* list.f */
design/ppu_pkg.sv
design/ppu_cfg_decode.sv
design/scanline_emu.sv
design/video_out_stage.sv
design/ppu_top.sv
dv/tb_ppu_top.sv
